//--- source/trace_cfg_pkg.sv
// Trace encoder configuration
// Field widths of the instruction trace encoder, the vector types that
// carry them, and the default depth of the packet buffer.

package trace_cfg_pkg;

    // address and software word
    localparam int XLEN        = 32;
    // exception cause and privilege level
    localparam int CAUSELEN    = 5;
    localparam int PRIVLEN     = 2;
    // timer value
    localparam int TIMER_WIDTH = 32;

    // branch map, up to 31 conditional branches
    localparam int BRANCHLEN   = 5;
    localparam int BMAP_LEN    = 31;

    // longest packet and its length field
    localparam int PACKET_LEN  = 72;
    localparam int PKT_LEN_W   = 7;

    localparam int PACKET_FIFO_DEPTH = 4;

    typedef logic [XLEN-1:0]        addr_t;
    typedef logic [CAUSELEN-1:0]    cause_t;
    typedef logic [PRIVLEN-1:0]     priv_t;
    typedef logic [TIMER_WIDTH-1:0] time_t;
    typedef logic [BRANCHLEN-1:0]   bcnt_t;
    typedef logic [BMAP_LEN-1:0]    bmap_t;
    typedef logic [PACKET_LEN-1:0]  pkt_bits_t;
    typedef logic [PKT_LEN_W-1:0]   pkt_len_t;

endpackage

//--- source/trace_packet_pkg.sv
// Trace packet definitions
// Packet kinds, trace formats and subformats, and the grouped signals
// passed between the branch map, the packet emitter and the packet FIFO.

package trace_packet_pkg;

    // bits 1:0 of every packet
    typedef enum logic [1:0] {
        W_SOFTWARE = 2'd1,
        W_TIME     = 2'd2,
        W_TRACE    = 2'd3
    } pkt_kind_e;

    // bits 3:2 of a trace packet
    typedef enum logic [1:0] {
        F_BRANCH_FULL = 2'd0,
        F_BRANCH_DIFF = 2'd1,
        F_ADDR_ONLY   = 2'd2,
        F_SYNC        = 2'd3
    } pkt_format_e;

    // only used with F_SYNC
    typedef enum logic [1:0] {
        SF_START     = 2'd0,
        SF_EXCEPTION = 2'd1,
        SF_CONTEXT   = 2'd2,
        SF_UNDEF     = 2'd3
    } pkt_subformat_e;

    // instruction state that comes with a trace request
    typedef struct packed {
        pkt_format_e           format;
        pkt_subformat_e        subformat;
        logic                  interrupt;
        trace_cfg_pkg::cause_t cause;
        trace_cfg_pkg::priv_t  priv;
        trace_cfg_pkg::addr_t  iaddr;
        logic                  is_branch;
        logic                  discontinuity;
    } trace_req_t;

    typedef struct packed {
        trace_cfg_pkg::bmap_t map;
        trace_cfg_pkg::bcnt_t count;
        logic                 full;
    } bmap_state_t;

    // formatted packet, unused high bits are zero
    typedef struct packed {
        trace_cfg_pkg::pkt_bits_t bits;
        trace_cfg_pkg::pkt_len_t  len;
    } packet_t;

endpackage

//--- source/branch_map.sv
// Branch map
// Records the taken/not-taken outcome of each retired conditional branch
// at the position given by the branch count. Holds at most 31 outcomes,
// flags full, and clears on a flush from the packet emitter.

`timescale 1ns/100ps

module branch_map (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          retire_valid_i,
    input  logic                          branch_valid_i,
    input  logic                          branch_taken_i,
    input  logic                          flush_i,
    output trace_packet_pkg::bmap_state_t state_o
);
    import trace_cfg_pkg::*;

    bmap_t map_q;
    bcnt_t count_q;
    logic  full;
    logic  branch_retired;

    assign full           = (count_q == bcnt_t'(BMAP_LEN));
    assign branch_retired = retire_valid_i && branch_valid_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // a branch retiring with the flush starts the new map
            if (branch_retired) begin
                map_q   <= bmap_t'(branch_taken_i);
                count_q <= bcnt_t'(1);
            end else begin
                map_q   <= '0;
                count_q <= '0;
            end
        end else if (branch_retired && !full) begin
            map_q[count_q] <= branch_taken_i;
            count_q        <= count_q + bcnt_t'(1);
        end
    end

    // outcomes beyond a full map are dropped

    assign state_o.map   = map_q;
    assign state_o.count = count_q;
    assign state_o.full  = full;

endmodule

//--- source/packet_emitter.sv
// Trace packet emitter
// Arbitrates trace, software and timer requests, one per cycle, in that
// order of priority, and formats the winner into packet bits and a length
// in bits. The packet is written into the FIFO in the request cycle.
// Each accepted trace request flushes the branch map one cycle later.

`timescale 1ns/100ps

module packet_emitter (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          trace_valid_i,
    input  trace_packet_pkg::trace_req_t  trace_req_i,
    input  trace_packet_pkg::bmap_state_t bmap_i,
    input  logic                          sw_valid_i,
    input  trace_cfg_pkg::addr_t          sw_word_i,
    input  logic                          tu_valid_i,
    input  trace_cfg_pkg::time_t          tu_time_i,
    input  logic                          fifo_not_full_i,
    output logic                          sw_grant_o,
    output logic                          tu_grant_o,
    output logic                          trace_lost_o,
    output logic                          bmap_flush_o,
    output trace_packet_pkg::packet_t     pkt_o,
    output logic                          pkt_write_o
);
    import trace_cfg_pkg::*;
    import trace_packet_pkg::*;

    logic    trace_accept;
    logic    trace_supported;
    logic    with_addr;
    logic    flush_q;
    bcnt_t   chunk;
    bmap_t   map_chunk;
    packet_t pkt;
    logic    pkt_write;

    // trace strobes are never held, a full FIFO loses them
    assign trace_accept = trace_valid_i && fifo_not_full_i;
    assign trace_lost_o = trace_valid_i && !fifo_not_full_i;

    // differential branch and context sync are not formatted
    assign trace_supported = (trace_req_i.format != F_BRANCH_DIFF) &&
        !((trace_req_i.format == F_SYNC) &&
          (trace_req_i.subformat inside {SF_CONTEXT, SF_UNDEF}));

    // map bits are sent in chunks of 1, 9, 17, 25 or 31
    always_comb begin
        if (bmap_i.count <= bcnt_t'(1)) begin
            chunk = bcnt_t'(1);
        end else if (bmap_i.count <= bcnt_t'(9)) begin
            chunk = bcnt_t'(9);
        end else if (bmap_i.count <= bcnt_t'(17)) begin
            chunk = bcnt_t'(17);
        end else if (bmap_i.count <= bcnt_t'(25)) begin
            chunk = bcnt_t'(25);
        end else begin
            chunk = bcnt_t'(BMAP_LEN);
        end
    end

    assign map_chunk = bmap_i.map & bmap_t'((32'd1 << chunk) - 32'd1);

    // a full map without discontinuity needs no address
    assign with_addr = !(bmap_i.full && !trace_req_i.discontinuity);

    always_comb begin
        pkt        = '0;
        pkt_write  = 1'b0;
        sw_grant_o = 1'b0;
        tu_grant_o = 1'b0;

        if (trace_valid_i) begin
            pkt.bits[1:0] = W_TRACE;
            pkt.bits[3:2] = trace_req_i.format;
            pkt_write     = trace_accept && trace_supported;

            case (trace_req_i.format)
                F_BRANCH_FULL: begin
                    pkt.bits[8:4] = bmap_i.count;
                    pkt.bits      = pkt.bits | (pkt_bits_t'(map_chunk) << 9);
                    if (with_addr) begin
                        pkt.bits = pkt.bits |
                                   (pkt_bits_t'(trace_req_i.iaddr) << (9 + chunk));
                        pkt.len  = pkt_len_t'(9 + chunk + XLEN);
                    end else begin
                        pkt.len  = pkt_len_t'(9 + chunk);
                    end
                end
                F_ADDR_ONLY: begin
                    pkt.bits[4 +: XLEN] = trace_req_i.iaddr;
                    pkt.len             = pkt_len_t'(4 + XLEN);
                end
                F_SYNC: begin
                    if (trace_req_i.subformat == SF_EXCEPTION) begin
                        pkt.bits[4 +: 2 + PRIVLEN + 1 + XLEN + CAUSELEN + 1] = {
                            trace_req_i.interrupt, trace_req_i.cause,
                            trace_req_i.iaddr, trace_req_i.is_branch,
                            trace_req_i.priv, trace_req_i.subformat};
                        pkt.len = pkt_len_t'(6 + PRIVLEN + 1 + XLEN + CAUSELEN + 1);
                    end else begin
                        pkt.bits[4 +: 2 + PRIVLEN + 1 + XLEN] = {
                            trace_req_i.iaddr, trace_req_i.is_branch,
                            trace_req_i.priv, trace_req_i.subformat};
                        pkt.len = pkt_len_t'(6 + PRIVLEN + 1 + XLEN);
                    end
                end
                default: begin
                    // F_BRANCH_DIFF is dropped
                    pkt.len = '0;
                end
            endcase
        end else if (sw_valid_i) begin
            sw_grant_o          = fifo_not_full_i;
            pkt_write           = fifo_not_full_i;
            pkt.bits[1:0]       = W_SOFTWARE;
            pkt.bits[2 +: XLEN] = sw_word_i;
            pkt.len             = pkt_len_t'(2 + XLEN);
        end else if (tu_valid_i) begin
            tu_grant_o                 = fifo_not_full_i;
            pkt_write                  = fifo_not_full_i;
            pkt.bits[1:0]              = W_TIME;
            pkt.bits[2 +: TIMER_WIDTH] = tu_time_i;
            pkt.len                    = pkt_len_t'(2 + TIMER_WIDTH);
        end
    end

    assign pkt_o       = pkt;
    assign pkt_write_o = pkt_write;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= trace_accept;
        end
    end

    assign bmap_flush_o = flush_q;

endmodule

//--- source/packet_fifo.sv
// Packet FIFO
// Circular buffer of formatted packets with an occupancy counter.
// Write side has a not-full flag, read side a valid/ready handshake.
// A write and a read may happen in the same cycle.

`timescale 1ns/100ps

module packet_fifo #(
    parameter int DEPTH = trace_cfg_pkg::PACKET_FIFO_DEPTH
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      wr_valid_i,
    input  trace_packet_pkg::packet_t wr_data_i,
    output logic                      not_full_o,
    output trace_packet_pkg::packet_t rd_data_o,
    output logic                      rd_valid_o,
    input  logic                      rd_ready_i
);
    import trace_packet_pkg::*;

    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

    packet_t mem [DEPTH];
    ptr_t    wr_ptr_q;
    ptr_t    rd_ptr_q;
    cnt_t    count_q;
    logic    push;
    logic    pop;

    assign not_full_o = (count_q != cnt_t'(DEPTH));
    assign rd_valid_o = (count_q != '0);
    assign rd_data_o  = mem[rd_ptr_q];

    assign push = wr_valid_i && not_full_o;
    assign pop  = rd_valid_o && rd_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

    // pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + ptr_t'(1);
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + ptr_t'(1);
            end
            if (push && !pop) begin
                count_q <= count_q + cnt_t'(1);
            end else if (pop && !push) begin
                count_q <= count_q - cnt_t'(1);
            end
        end
    end

endmodule

//--- source/trace_packet_top.sv
// Trace packet stage
// Retired branches fill the branch map, the emitter formats trace,
// software and timer requests into packets, and the FIFO hands them
// to the output port under a valid/ready handshake.

`timescale 1ns/100ps

module trace_packet_top (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         retire_valid_i,
    input  logic                         branch_valid_i,
    input  logic                         branch_taken_i,
    input  logic                         trace_valid_i,
    input  trace_packet_pkg::trace_req_t trace_req_i,
    input  logic                         sw_valid_i,
    input  trace_cfg_pkg::addr_t         sw_word_i,
    output logic                         sw_grant_o,
    input  logic                         tu_valid_i,
    input  trace_cfg_pkg::time_t         tu_time_i,
    output logic                         tu_grant_o,
    output trace_packet_pkg::packet_t    packet_o,
    output logic                         packet_valid_o,
    input  logic                         packet_ready_i,
    output logic                         trace_lost_o
);
    import trace_packet_pkg::*;

    bmap_state_t bmap_state;
    logic        bmap_flush;
    packet_t     pkt;
    logic        pkt_write;
    logic        fifo_not_full;

    branch_map branch_map_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .retire_valid_i (retire_valid_i),
        .branch_valid_i (branch_valid_i),
        .branch_taken_i (branch_taken_i),
        .flush_i        (bmap_flush),
        .state_o        (bmap_state)
    );

    packet_emitter packet_emitter_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .trace_valid_i   (trace_valid_i),
        .trace_req_i     (trace_req_i),
        .bmap_i          (bmap_state),
        .sw_valid_i      (sw_valid_i),
        .sw_word_i       (sw_word_i),
        .tu_valid_i      (tu_valid_i),
        .tu_time_i       (tu_time_i),
        .fifo_not_full_i (fifo_not_full),
        .sw_grant_o      (sw_grant_o),
        .tu_grant_o      (tu_grant_o),
        .trace_lost_o    (trace_lost_o),
        .bmap_flush_o    (bmap_flush),
        .pkt_o           (pkt),
        .pkt_write_o     (pkt_write)
    );

    packet_fifo packet_fifo_i (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .wr_valid_i (pkt_write),
        .wr_data_i  (pkt),
        .not_full_o (fifo_not_full),
        .rd_data_o  (packet_o),
        .rd_valid_o (packet_valid_o),
        .rd_ready_i (packet_ready_i)
    );

endmodule

//--- sim/trace_packet_assert.sv
// Trace packet assertions
// Concurrent checks on the packet emitter and the FIFO write side that it
// drives: no write into a full FIFO, at most one grant per cycle, and no
// packet written for an unsupported trace format.

`timescale 1ns/100ps

module trace_packet_assert (
    input logic                         clk_i,
    input logic                         rst_ni,
    input logic                         trace_valid_i,
    input trace_packet_pkg::trace_req_t trace_req_i,
    input logic                         pkt_write_i,
    input logic                         fifo_not_full_i,
    input logic                         sw_grant_i,
    input logic                         tu_grant_i
);
    import trace_packet_pkg::*;

    logic unsupported;
    // number of failed assertions, read by the testbench at the end
    int   failures = 0;

    assign unsupported = (trace_req_i.format == F_BRANCH_DIFF) ||
        ((trace_req_i.format == F_SYNC) && (trace_req_i.subformat inside {SF_CONTEXT, SF_UNDEF}));

    write_not_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pkt_write_i |-> fifo_not_full_i)
        else begin
            failures++;
            $error("packet written while the FIFO is full");
        end

    one_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(sw_grant_i && tu_grant_i))
        else begin
            failures++;
            $error("software and timer granted in the same cycle");
        end

    supported_only: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (pkt_write_i && trace_valid_i) |-> !unsupported)
        else begin
            failures++;
            $error("unsupported trace format written into the FIFO");
        end

endmodule

bind packet_emitter trace_packet_assert trace_packet_assert_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .trace_valid_i   (trace_valid_i),
    .trace_req_i     (trace_req_i),
    .pkt_write_i     (pkt_write_o),
    .fifo_not_full_i (fifo_not_full_i),
    .sw_grant_i      (sw_grant_o),
    .tu_grant_i      (tu_grant_o)
);

//--- sim/tb_trace_packet.sv
// Trace packet stage testbench
// Directed tests for branch-full, address-only, sync, software and timer
// packets, request priority and FIFO back-pressure. Expected packets come
// from a model of the packet layout and a model of the branch map.

`timescale 1ns/100ps

module tb_trace_packet;
    import trace_cfg_pkg::*;
    import trace_packet_pkg::*;

    // tests need about 200 cycles
    localparam int MAX_CYCLES = 2000;

    logic        clk_i;
    logic        rst_ni;
    logic        retire_valid_i;
    logic        branch_valid_i;
    logic        branch_taken_i;
    logic        trace_valid_i;
    trace_req_t  trace_req_i;
    logic        sw_valid_i;
    addr_t       sw_word_i;
    logic        sw_grant_o;
    logic        tu_valid_i;
    time_t       tu_time_i;
    logic        tu_grant_o;
    packet_t     packet_o;
    logic        packet_valid_o;
    logic        packet_ready_i;
    logic        trace_lost_o;

    logic [31:0] lfsr = 32'h511d_6528;
    bmap_t       model_map;
    int          model_count;
    packet_t     exp_q[$];
    int          errors;
    int          cycles;

    trace_packet_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(string name, logic [127:0] got, logic [127:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Done: errors found");
            $fatal(1, "first error");
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic next_random_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic trace_req_t make_req(pkt_format_e fmt, pkt_subformat_e sf, addr_t addr,
                                            logic disc);
        trace_req_t r;
        r.format = fmt;
        r.subformat = sf;
        r.interrupt = addr[4];
        r.cause = addr[9:5];
        r.priv = addr[3:2];
        r.iaddr = addr;
        r.is_branch = addr[2];
        r.discontinuity = disc;
        return r;
    endfunction

    function automatic packet_t model_trace(trace_req_t r, bmap_t map, int count);
        packet_t p;
        int chunk;
        int i;
        p = '0;
        p.bits[1:0] = 2'd3;
        p.bits[3:2] = r.format;
        if (r.format == F_BRANCH_FULL) begin
            chunk = (count <= 1) ? 1 : (count <= 9) ? 9 : (count <= 17) ? 17 :
                    (count <= 25) ? 25 : 31;
            p.bits[8:4] = 5'(count);
            for (i = 0; i < chunk; i++) begin
                p.bits[9 + i] = map[i];
            end
            if (count == 31 && !r.discontinuity) begin
                p.len = pkt_len_t'(40);
            end else begin
                for (i = 0; i < 32; i++) begin
                    p.bits[9 + chunk + i] = r.iaddr[i];
                end
                p.len = pkt_len_t'(9 + chunk + 32);
            end
        end else if (r.format == F_ADDR_ONLY) begin
            p.bits[35:4] = r.iaddr;
            p.len = pkt_len_t'(36);
        end else begin
            p.bits[5:4] = r.subformat;
            p.bits[7:6] = r.priv;
            p.bits[8] = r.is_branch;
            p.bits[40:9] = r.iaddr;
            p.len = pkt_len_t'(41);
            if (r.subformat == SF_EXCEPTION) begin
                p.bits[45:41] = r.cause;
                p.bits[46] = r.interrupt;
                p.len = pkt_len_t'(47);
            end
        end
        return p;
    endfunction

    function automatic packet_t model_word(logic [1:0] kind, logic [31:0] word);
        packet_t p;
        p = '0;
        p.bits[1:0] = kind;
        p.bits[33:2] = word;
        p.len = pkt_len_t'(34);
        return p;
    endfunction

    task automatic retire_branches(int n);
        for (int i = 0; i < n; i++) begin
            retire_valid_i = 1'b1;
            branch_valid_i = 1'b1;
            branch_taken_i = next_random_bit();
            if (model_count < 31) begin
                model_map[model_count] = branch_taken_i;
                model_count++;
            end
            @(posedge clk_i);
            #10;
        end
        retire_valid_i = 1'b0;
        branch_valid_i = 1'b0;
    endtask

    task automatic send_trace(trace_req_t req, logic expect_lost);
        trace_valid_i = 1'b1;
        trace_req_i = req;
        @(negedge clk_i);
        check_value("trace_lost_o", trace_lost_o, expect_lost);
        if (!expect_lost) begin
            // differential branch and context sync produce no packet
            if (!(req.format == F_BRANCH_DIFF ||
                  (req.format == F_SYNC && req.subformat inside {SF_CONTEXT, SF_UNDEF}))) begin
                exp_q.push_back(model_trace(req, model_map, model_count));
            end
            model_map = '0;
            model_count = 0;
        end
        @(posedge clk_i);
        #10;
        trace_valid_i = 1'b0;
    endtask

    task automatic request_word(logic is_timer, logic [31:0] word);
        if (is_timer) begin
            tu_valid_i = 1'b1;
            tu_time_i = word;
        end else begin
            sw_valid_i = 1'b1;
            sw_word_i = word;
        end
        @(negedge clk_i);
        while (!(is_timer ? tu_grant_o : sw_grant_o)) @(negedge clk_i);
        exp_q.push_back(model_word(is_timer ? 2'd2 : 2'd1, word));
        @(posedge clk_i);
        #10;
        tu_valid_i = 1'b0;
        sw_valid_i = 1'b0;
    endtask

    task automatic drain_expected();
        packet_t exp;
        packet_ready_i = 1'b1;
        while (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            @(negedge clk_i);
            while (!packet_valid_o) @(negedge clk_i);
            check_value("packet_o", packet_o, exp);
            @(posedge clk_i);
            #10;
        end
        packet_ready_i = 1'b0;
        // nothing beyond the expected packets
        @(negedge clk_i);
        check_value("packet_valid_o", packet_valid_o, 1'b0);
        @(posedge clk_i);
        #10;
    endtask

    task automatic outputs_after_reset();
        @(negedge clk_i);
        check_value("packet_valid_o", packet_valid_o, 1'b0);
        check_value("sw_grant_o", sw_grant_o, 1'b0);
        check_value("tu_grant_o", tu_grant_o, 1'b0);
        check_value("trace_lost_o", trace_lost_o, 1'b0);
        check_value("bmap_flush", dut_i.bmap_flush, 1'b0);
        @(posedge clk_i);
        #10;
    endtask

    task automatic branch_full_packets();
        int counts[7] = '{1, 5, 12, 20, 28, 31, 33};
        int carry;
        carry = 0;
        for (int i = 0; i < 7; i++) begin
            retire_branches(counts[i] - carry);
            send_trace(make_req(F_BRANCH_FULL, SF_START, addr_t'(32'h8000_0100 + i * 68),
                                i[0]), 1'b0);
            // retires together with the flush, lands at bit 0
            retire_branches(1);
            carry = 1;
            drain_expected();
        end
    endtask

    task automatic address_and_sync_packets();
        retire_branches(4);
        send_trace(make_req(F_ADDR_ONLY, SF_START, 32'h1234_5678, 1'b0), 1'b0);
        send_trace(make_req(F_SYNC, SF_START, 32'hdead_beec, 1'b1), 1'b0);
        send_trace(make_req(F_SYNC, SF_EXCEPTION, 32'h0bad_f00d, 1'b0), 1'b0);
        send_trace(make_req(F_BRANCH_DIFF, SF_START, 32'h4000_0000, 1'b0), 1'b0);
        send_trace(make_req(F_SYNC, SF_CONTEXT, 32'h4000_0010, 1'b0), 1'b0);
        drain_expected();
    endtask

    task automatic word_packets_and_priority();
        trace_req_t req;
        request_word(1'b0, 32'hcafe_0001);
        request_word(1'b1, 32'h0000_abcd);
        drain_expected();
        req = make_req(F_ADDR_ONLY, SF_START, 32'h2000_0040, 1'b0);
        trace_valid_i = 1'b1;
        trace_req_i = req;
        sw_valid_i = 1'b1;
        sw_word_i = 32'h5555_aaaa;
        tu_valid_i = 1'b1;
        tu_time_i = 32'h0001_0000;
        @(negedge clk_i);
        check_value("sw_grant_o", sw_grant_o, 1'b0);
        check_value("tu_grant_o", tu_grant_o, 1'b0);
        exp_q.push_back(model_trace(req, model_map, model_count));
        model_map = '0;
        model_count = 0;
        @(posedge clk_i);
        #10;
        trace_valid_i = 1'b0;
        @(negedge clk_i);
        check_value("sw_grant_o", sw_grant_o, 1'b1);
        check_value("tu_grant_o", tu_grant_o, 1'b0);
        exp_q.push_back(model_word(2'd1, sw_word_i));
        @(posedge clk_i);
        #10;
        sw_valid_i = 1'b0;
        @(negedge clk_i);
        check_value("tu_grant_o", tu_grant_o, 1'b1);
        check_value("sw_grant_o", sw_grant_o, 1'b0);
        exp_q.push_back(model_word(2'd2, tu_time_i));
        @(posedge clk_i);
        #10;
        tu_valid_i = 1'b0;
        drain_expected();
    endtask

    task automatic full_fifo_backpressure();
        for (int i = 0; i < PACKET_FIFO_DEPTH; i++) begin
            request_word(i[0], addr_t'(32'h7000_0000 + i * 3));
        end
        sw_valid_i = 1'b1;
        sw_word_i = 32'h0f0f_0f0f;
        repeat (3) begin
            @(negedge clk_i);
            check_value("sw_grant_o", sw_grant_o, 1'b0);
            @(posedge clk_i);
            #10;
        end
        send_trace(make_req(F_ADDR_ONLY, SF_START, 32'h3000_0000, 1'b0), 1'b1);
        sw_valid_i = 1'b0;
        drain_expected();
    endtask

    initial begin
        rst_ni = 1'b0;
        retire_valid_i = 1'b0;
        branch_valid_i = 1'b0;
        branch_taken_i = 1'b0;
        trace_valid_i = 1'b0;
        trace_req_i = '0;
        sw_valid_i = 1'b0;
        sw_word_i = '0;
        tu_valid_i = 1'b0;
        tu_time_i = '0;
        packet_ready_i = 1'b0;
        model_map = '0;
        model_count = 0;
        errors = 0;
        cycles = 0;
        repeat (5) @(posedge clk_i);
        #10;
        rst_ni = 1'b1;
        outputs_after_reset();
        branch_full_packets();
        address_and_sync_packets();
        word_packets_and_priority();
        full_fifo_backpressure();
        // concurrent checks on the emitter and FIFO write side
        errors = dut_i.packet_emitter_i.trace_packet_assert_i.failures;
        if (errors == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("%0d bound assertions failed during the run", errors);
            $display("Done: errors found");
            $fatal(1, "bound assertion failures");
        end
    end

endmodule

//--- project.f
source/trace_cfg_pkg.sv
source/trace_packet_pkg.sv
source/branch_map.sv
source/packet_emitter.sv
source/packet_fifo.sv
source/trace_packet_top.sv
sim/trace_packet_assert.sv
sim/tb_trace_packet.sv
